// ==== hdl/fpadd_barrel_shifter.sv ====
module fpadd_barrel_shifter (
  input  logic                       clk,
  input  logic                       reset_i,
  input  logic                       align_active_i,
  input  logic                       norm_active_i,
  input  logic [fpadd_pkg::SW-1:0]   minor_frac_i,
  input  logic [fpadd_pkg::EWR-1:0]  align_amount_i,
  input  logic [fpadd_pkg::SWR-1:0]  raw_sig_i,
  input  logic                       carry_i,
  input  logic [fpadd_pkg::EWR-1:0]  lz_count_i,
  output logic [fpadd_pkg::SWR-1:0]  shifted_o
);

  // Bit order reversal, turns the right shifter into a left shifter
  function automatic logic [fpadd_pkg::SWR-1:0] flip(input logic [fpadd_pkg::SWR-1:0] d);
    logic [fpadd_pkg::SWR-1:0] r;
    for (int i = 0; i < fpadd_pkg::SWR; i++) begin
      r[i] = d[fpadd_pkg::SWR-1-i];
    end
    return r;
  endfunction

  // One level: right shift by n, vacated MSBs take the fill bit
  function automatic logic [fpadd_pkg::SWR-1:0] shr_fill(
    input logic [fpadd_pkg::SWR-1:0] d,
    input int                        n,
    input logic                      f
  );
    logic [fpadd_pkg::SWR-1:0] mask;
    mask = ~({fpadd_pkg::SWR{1'b1}} >> n);
    return (d >> n) | (mask & {fpadd_pkg::SWR{f}});
  endfunction

  logic [fpadd_pkg::SWR-1:0]                       src;
  logic [fpadd_pkg::EWR-1:0]                       amt;
  logic                                            left;
  logic                                            fill;
  logic [fpadd_pkg::SWR-1:0]                       half_a;
  logic [fpadd_pkg::SWR-1:0]                       mid_data_q;
  logic [fpadd_pkg::EWR-fpadd_pkg::SHT1_LEVELS-1:0] mid_amt_q;
  logic                                            mid_left_q;
  logic                                            mid_fill_q;
  logic [fpadd_pkg::SWR-1:0]                       half_b;

  // ========================================
  // First half, SHT1 or NRM
  // ========================================

  // Align source: smaller operand with hidden bit and guard bits
  assign src = norm_active_i ? raw_sig_i : {1'b1, minor_frac_i, 2'b00};

  // Carry out of the adder means one place right, else left by the LZD count
  assign amt  = norm_active_i ? (carry_i ? {{(fpadd_pkg::EWR-1){1'b0}}, 1'b1} : lz_count_i)
                              : align_amount_i;
  assign left = norm_active_i & ~carry_i;
  assign fill = norm_active_i & carry_i;

  always_comb begin
    half_a = left ? flip(src) : src;
    for (int k = 0; k < fpadd_pkg::SHT1_LEVELS; k++) begin
      if (amt[k]) begin
        half_a = shr_fill(half_a, 1 << k, fill);
      end
    end
  end

  // ========================================
  // Mid register
  // ========================================

  always_ff @(posedge clk) begin
    if (align_active_i | norm_active_i) begin
      mid_data_q <= half_a;
      // Low amount bits are already spent
      mid_amt_q  <= amt[fpadd_pkg::EWR-1:fpadd_pkg::SHT1_LEVELS];
    end
  end

  // Direction and fill follow the data
  always_ff @(posedge clk) begin
    if (reset_i) begin
      mid_left_q <= 1'b0;
      mid_fill_q <= 1'b0;
    end else if (align_active_i | norm_active_i) begin
      mid_left_q <= left;
      mid_fill_q <= fill;
    end
  end

  // ========================================
  // Second half, SHT2 or NRM2
  // ========================================

  always_comb begin
    half_b = mid_data_q;
    for (int k = fpadd_pkg::SHT1_LEVELS; k < fpadd_pkg::EWR; k++) begin
      if (mid_amt_q[k - fpadd_pkg::SHT1_LEVELS]) begin
        half_b = shr_fill(half_b, 1 << k, mid_fill_q);
      end
    end
  end

  // Undo the reversal for a left shift
  assign shifted_o = mid_left_q ? flip(half_b) : half_b;

endmodule

// ==== hdl/fpadd_formatter.sv ====
module fpadd_formatter (
  input  logic [fpadd_pkg::EW-1:0]  major_exp_i,
  input  logic [fpadd_pkg::EWR-1:0] lz_count_i,
  input  logic                      carry_i,
  input  logic                      sign_i,
  input  logic                      zero_i,
  input  logic [fpadd_pkg::SWR-1:0] norm_sig_i,
  output logic [fpadd_pkg::W-1:0]   packed_o,
  output logic                      overflow_o,
  output logic                      underflow_o
);

  // One extra bit, top bit set means the exponent went negative
  logic [fpadd_pkg::EW:0] exp_new;
  logic                   exp_over;
  logic                   exp_under;

  // ========================================
  // Exponent adjust
  // ========================================

  assign exp_new = carry_i ? {1'b0, major_exp_i} + 1'b1
                           : {1'b0, major_exp_i}
                             - {{(fpadd_pkg::EW+1-fpadd_pkg::EWR){1'b0}}, lz_count_i};

  // Only the carry path can pass EXP_MAX
  assign exp_over  = ~exp_new[fpadd_pkg::EW] & (exp_new[fpadd_pkg::EW-1:0] > fpadd_pkg::EXP_MAX);
  // Zero or negative
  assign exp_under = exp_new[fpadd_pkg::EW] | (exp_new == '0);

  // Exact zero masks both flags
  assign overflow_o  = ~zero_i & exp_over;
  assign underflow_o = ~zero_i & exp_under;

  // ========================================
  // Packing
  // ========================================

  always_comb begin
    if (zero_i) begin
      packed_o = '0;
    end else if (exp_over) begin
      // Signed infinity
      packed_o = {sign_i, {fpadd_pkg::EW{1'b1}}, {fpadd_pkg::SW{1'b0}}};
    end else if (exp_under) begin
      // Signed zero
      packed_o = {sign_i, {(fpadd_pkg::W-1){1'b0}}};
    end else begin
      // Hidden bit and guard bits dropped, truncation
      packed_o = {sign_i, exp_new[fpadd_pkg::EW-1:0], norm_sig_i[fpadd_pkg::SWR-2:2]};
    end
  end

endmodule

// ==== hdl/fpadd_lzd.sv ====
module fpadd_lzd (
  input  logic [fpadd_pkg::SWR-1:0] raw_sig_i,
  output logic [fpadd_pkg::EWR-1:0] lz_count_o
);

  // Running count and first-one marker
  logic [fpadd_pkg::EWR-1:0] count;
  logic                      found;

  // ========================================
  // Priority scan from the MSB
  // ========================================

  always_comb begin
    count = '0;
    found = 1'b0;
    for (int i = fpadd_pkg::SWR-1; i >= 0; i--) begin
      if (raw_sig_i[i]) begin
        // First one stops the count
        found = 1'b1;
      end else if (!found) begin
        count = count + 1'b1;
      end
    end
  end

  // All-zero input ends at SWR
  assign lz_count_o = count;

endmodule

// ==== hdl/fpadd_operand_sort.sv ====
module fpadd_operand_sort (
  input  logic [fpadd_pkg::W-1:0] op_x_i,
  input  logic [fpadd_pkg::W-1:0] op_y_i,
  input  logic                    add_subt_i,
  output logic [fpadd_pkg::W-2:0] major_o,
  output logic [fpadd_pkg::W-2:0] minor_o,
  output logic                    op_eff_o,
  output logic                    sign_o,
  output logic                    zero_o
);

  // Magnitudes without the sign bit
  logic [fpadd_pkg::W-2:0] mag_x;
  logic [fpadd_pkg::W-2:0] mag_y;
  logic                    sign_x;
  logic                    sign_y;
  logic                    x_wins;
  logic                    equal;

  assign mag_x  = op_x_i[fpadd_pkg::W-2:0];
  assign mag_y  = op_y_i[fpadd_pkg::W-2:0];
  assign sign_x = op_x_i[fpadd_pkg::W-1];
  assign sign_y = op_y_i[fpadd_pkg::W-1];

  // Exponent sits above the fraction, so an integer compare orders them
  assign x_wins = (mag_x >= mag_y);
  assign equal  = (mag_x == mag_y);

  // Larger magnitude goes to the major slot
  assign major_o = x_wins ? mag_x : mag_y;
  assign minor_o = x_wins ? mag_y : mag_x;

  // Subtract when the signs differ, flipped again by a requested subtract
  assign op_eff_o = sign_x ^ sign_y ^ add_subt_i;

  // Exact cancellation
  assign zero_o = op_eff_o & equal;

  always_comb begin
    if (zero_o) begin
      // Cancellation gives +0
      sign_o = 1'b0;
    end else if (x_wins) begin
      sign_o = sign_x;
    end else begin
      // Y dominates, negated by a subtract
      sign_o = sign_y ^ add_subt_i;
    end
  end

endmodule

// ==== hdl/fpadd_pkg.sv ====
package fpadd_pkg;

  // ========================================
  // Single precision word layout
  // ========================================

  // Full IEEE-754 word
  localparam int W = 32;

  // Biased exponent field
  localparam int EW = 8;

  // Stored fraction field, hidden bit not included
  localparam int SW = 23;

  // Working significand: hidden bit, fraction, two guard bits
  localparam int SWR = SW + 3;

  // Shift amount width, covers any shift up to SWR
  localparam int EWR = 5;

  // Largest finite biased exponent, 254
  localparam logic [EW-1:0] EXP_MAX = {{(EW-1){1'b1}}, 1'b0};

  // ========================================
  // Activity chain
  // ========================================

  localparam int N_STAGES = 7;

  // Token positions, oldest stage in the lowest bit
  localparam int ST_INIT = 0;
  localparam int ST_EXP  = 1;
  localparam int ST_SHT1 = 2;
  localparam int ST_SHT2 = 3;
  localparam int ST_SGF  = 4;
  localparam int ST_NRM  = 5;
  localparam int ST_NRM2 = 6;

  // Shifter levels ahead of the mid register
  localparam int SHT1_LEVELS = 2;

endpackage

// ==== hdl/fpadd_stage_ctrl.sv ====
module fpadd_stage_ctrl (
  input  logic                           clk,
  input  logic                           reset_i,
  input  logic                           start_i,
  output logic [fpadd_pkg::N_STAGES-1:0] stage_active_o,
  output logic                           load_input_o,
  output logic                           busy_o,
  output logic                           ready_o
);

  // One bit per stage, a set bit marks an operation in that stage
  logic [fpadd_pkg::N_STAGES-1:0] token_q;
  logic                           ready_q;

  // ========================================
  // Start acceptance
  // ========================================

  // Shifter first half is taken while a token sits in SHT1
  assign busy_o = token_q[fpadd_pkg::ST_SHT1];

  // Start while busy is dropped
  assign load_input_o = start_i & ~busy_o;

  // ========================================
  // Token chain and ready pulse
  // ========================================

  always_ff @(posedge clk) begin
    if (reset_i) begin
      token_q <= '0;
      ready_q <= 1'b0;
    end else begin
      // New token enters INIT, all others move one stage on
      token_q <= {token_q[fpadd_pkg::N_STAGES-2:0], load_input_o};
      // Result register loads on the same edge
      ready_q <= token_q[fpadd_pkg::ST_NRM2];
    end
  end

  assign stage_active_o = token_q;
  assign ready_o        = ready_q;

endmodule

// ==== hdl/fpadd_top.sv ====
module fpadd_top (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    start_i,
  input  logic [fpadd_pkg::W-1:0] data_x_i,
  input  logic [fpadd_pkg::W-1:0] data_y_i,
  input  logic                    add_subt_i,
  output logic                    busy_o,
  output logic                    ready_o,
  output logic [fpadd_pkg::W-1:0] result_o,
  output logic                    overflow_o,
  output logic                    underflow_o,
  output logic                    zero_o
);

  logic [fpadd_pkg::N_STAGES-1:0] stage_active;
  logic                           load_input;

  // Input register
  logic [fpadd_pkg::W-1:0]   x_q, y_q;
  logic                      as_q;
  // INIT results
  logic [fpadd_pkg::W-2:0]   init_major, init_minor;
  logic                      init_op, init_sign, init_zero;
  // EXP register and shift amount
  logic [fpadd_pkg::W-2:0]   e_major_q, e_minor_q;
  logic                      e_op_q, e_sign_q, e_zero_q;
  logic [fpadd_pkg::EW-1:0]  exp_diff;
  logic [fpadd_pkg::EWR-1:0] align_amt;
  // SHT1 and SHT2 registers
  logic [fpadd_pkg::W-2:0]   s1_major_q, s2_major_q;
  logic [fpadd_pkg::SW-1:0]  s1_minor_frac_q;
  logic [fpadd_pkg::EWR-1:0] s1_amt_q;
  logic                      s1_op_q, s1_sign_q, s1_zero_q;
  logic                      s2_op_q, s2_sign_q, s2_zero_q;
  // SGF register and adder
  logic [fpadd_pkg::W-2:0]   g_major_q;
  logic [fpadd_pkg::SWR-1:0] g_minor_sig_q, g_major_sig;
  logic                      g_op_q, g_sign_q, g_zero_q;
  logic [fpadd_pkg::SWR:0]   sum;
  // NRM and NRM2 registers
  logic [fpadd_pkg::SWR-1:0] n_raw_q;
  logic [fpadd_pkg::EW-1:0]  n_exp_q, n2_exp_q;
  logic                      n_carry_q, n_sign_q, n_zero_q;
  logic [fpadd_pkg::EWR-1:0] n_lz, n2_lz_q;
  logic                      n2_carry_q, n2_sign_q, n2_zero_q;
  // Shifter and formatter outputs
  logic [fpadd_pkg::SWR-1:0] shifted;
  logic [fpadd_pkg::W-1:0]   fmt_word;
  logic                      fmt_over, fmt_under;

  fpadd_stage_ctrl u_ctrl (
    .clk            (clk),
    .reset_i        (reset_i),
    .start_i        (start_i),
    .stage_active_o (stage_active),
    .load_input_o   (load_input),
    .busy_o         (busy_o),
    .ready_o        (ready_o)
  );

  // ========================================
  // Input and INIT
  // ========================================

  always_ff @(posedge clk) begin
    if (load_input) begin
      x_q  <= data_x_i;
      y_q  <= data_y_i;
      as_q <= add_subt_i;
    end
  end

  fpadd_operand_sort u_sort (
    .op_x_i     (x_q),
    .op_y_i     (y_q),
    .add_subt_i (as_q),
    .major_o    (init_major),
    .minor_o    (init_minor),
    .op_eff_o   (init_op),
    .sign_o     (init_sign),
    .zero_o     (init_zero)
  );

  // ========================================
  // EXP, exponent difference
  // ========================================

  always_ff @(posedge clk) begin
    if (stage_active[fpadd_pkg::ST_INIT]) begin
      e_major_q <= init_major;
      e_minor_q <= init_minor;
      {e_op_q, e_sign_q, e_zero_q} <= {init_op, init_sign, init_zero};
    end
  end

  // Major exponent is never the smaller one
  assign exp_diff = e_major_q[fpadd_pkg::W-2:fpadd_pkg::SW] - e_minor_q[fpadd_pkg::W-2:fpadd_pkg::SW];
  // Large gaps saturate, the minor operand shifts out entirely
  assign align_amt = (|exp_diff[fpadd_pkg::EW-1:fpadd_pkg::EWR]) ? '1
                                                                 : exp_diff[fpadd_pkg::EWR-1:0];

  // ========================================
  // SHT1 and SHT2
  // ========================================

  always_ff @(posedge clk) begin
    if (stage_active[fpadd_pkg::ST_EXP]) begin
      s1_major_q      <= e_major_q;
      s1_minor_frac_q <= e_minor_q[fpadd_pkg::SW-1:0];
      s1_amt_q        <= align_amt;
      {s1_op_q, s1_sign_q, s1_zero_q} <= {e_op_q, e_sign_q, e_zero_q};
    end
    if (stage_active[fpadd_pkg::ST_SHT1]) begin
      s2_major_q <= s1_major_q;
      {s2_op_q, s2_sign_q, s2_zero_q} <= {s1_op_q, s1_sign_q, s1_zero_q};
    end
  end

  // Alignment in SHT1/SHT2, normalisation in NRM/NRM2
  fpadd_barrel_shifter u_shift (
    .clk            (clk),
    .reset_i        (reset_i),
    .align_active_i (stage_active[fpadd_pkg::ST_SHT1]),
    .norm_active_i  (stage_active[fpadd_pkg::ST_NRM]),
    .minor_frac_i   (s1_minor_frac_q),
    .align_amount_i (s1_amt_q),
    .raw_sig_i      (n_raw_q),
    .carry_i        (n_carry_q),
    .lz_count_i     (n_lz),
    .shifted_o      (shifted)
  );

  // ========================================
  // SGF, significand add or subtract
  // ========================================

  always_ff @(posedge clk) begin
    if (stage_active[fpadd_pkg::ST_SHT2]) begin
      g_major_q     <= s2_major_q;
      g_minor_sig_q <= shifted;
      {g_op_q, g_sign_q, g_zero_q} <= {s2_op_q, s2_sign_q, s2_zero_q};
    end
  end

  assign g_major_sig = {1'b1, g_major_q[fpadd_pkg::SW-1:0], 2'b00};
  assign sum = g_op_q ? {1'b0, g_major_sig} - {1'b0, g_minor_sig_q}
                      : {1'b0, g_major_sig} + {1'b0, g_minor_sig_q};

  // ========================================
  // NRM and NRM2
  // ========================================

  always_ff @(posedge clk) begin
    if (stage_active[fpadd_pkg::ST_SGF]) begin
      n_raw_q   <= sum[fpadd_pkg::SWR-1:0];
      n_exp_q   <= g_major_q[fpadd_pkg::W-2:fpadd_pkg::SW];
      // Borrow out of a subtract is not a carry
      n_carry_q <= sum[fpadd_pkg::SWR] & ~g_op_q;
      {n_sign_q, n_zero_q} <= {g_sign_q, g_zero_q};
    end
    if (stage_active[fpadd_pkg::ST_NRM]) begin
      n2_exp_q <= n_exp_q;
      n2_lz_q  <= n_lz;
      {n2_carry_q, n2_sign_q, n2_zero_q} <= {n_carry_q, n_sign_q, n_zero_q};
    end
  end

  fpadd_lzd u_lzd (
    .raw_sig_i  (n_raw_q),
    .lz_count_o (n_lz)
  );

  fpadd_formatter u_fmt (
    .major_exp_i (n2_exp_q),
    .lz_count_i  (n2_lz_q),
    .carry_i     (n2_carry_q),
    .sign_i      (n2_sign_q),
    .zero_i      (n2_zero_q),
    .norm_sig_i  (shifted),
    .packed_o    (fmt_word),
    .overflow_o  (fmt_over),
    .underflow_o (fmt_under)
  );

  // ========================================
  // Output register
  // ========================================

  always_ff @(posedge clk) begin
    if (reset_i) begin
      result_o    <= '0;
      overflow_o  <= 1'b0;
      underflow_o <= 1'b0;
      zero_o      <= 1'b0;
    end else if (stage_active[fpadd_pkg::ST_NRM2]) begin
      // Same edge as ready
      result_o    <= fmt_word;
      overflow_o  <= fmt_over;
      underflow_o <= fmt_under;
      zero_o      <= n2_zero_q;
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Compile with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert --top-module fpadd_tb -f verilog.f -o fpadd_sim \
    > build.log 2>&1 \
  && ./obj_dir/fpadd_sim 2>&1 | tee sim.log \
  && grep -q "^ALL TESTS PASSED$" sim.log \
  && echo "run.sh: simulation passed" \
  && exit 0 \
  || { echo "run.sh: build or simulation failed, see build.log and sim.log"; exit 1; }

// ==== testbench/fpadd_chk.sv ====
module fpadd_chk (
  input logic clk,
  input logic reset_i,
  input logic start_i,
  input logic busy_i,
  input logic ready_i,
  input logic overflow_i,
  input logic underflow_i
);

  // Start taken by the stage control
  logic accept;

  assign accept = start_i & ~busy_i;

  // ========================================
  // Start to result latency
  // ========================================

  // Ready rises on the seventh edge and is first sampled on the eighth
  a_start_gives_result: assert property (@(posedge clk) disable iff (reset_i)
    $past(accept, 7) |=> ready_i)
    else $error("accepted start gave no ready pulse seven cycles later");

  // Starts dropped while busy must give no result
  a_result_has_start: assert property (@(posedge clk) disable iff (reset_i)
    ready_i |-> $past(accept, 8))
    else $error("ready pulse with no accepted start seven cycles before");

  // ========================================
  // Result flags
  // ========================================

  a_flags_exclusive: assert property (@(posedge clk) disable iff (reset_i)
    !(overflow_i && underflow_i))
    else $error("overflow and underflow flagged together");

endmodule

bind fpadd_top fpadd_chk u_chk (
  .clk         (clk),
  .reset_i     (reset_i),
  .start_i     (start_i),
  .busy_i      (busy_o),
  .ready_i     (ready_o),
  .overflow_i  (overflow_o),
  .underflow_i (underflow_o)
);

// ==== testbench/fpadd_tb.sv ====
module fpadd_tb;

  localparam int PERIOD    = 4;
  localparam int N_VEC     = 17;
  // Watchdog limit in clock periods
  localparam int WD_CYCLES = N_VEC * 10 + 50;

  logic                    clk;
  logic                    reset_i;
  logic                    start_i;
  logic [fpadd_pkg::W-1:0] data_x_i;
  logic [fpadd_pkg::W-1:0] data_y_i;
  logic                    add_subt_i;
  logic                    busy_o;
  logic                    ready_o;
  logic [fpadd_pkg::W-1:0] result_o;
  logic                    overflow_o;
  logic                    underflow_o;
  logic                    zero_o;

  // Stimulus table with flags packed as {overflow, underflow, zero}
  logic [fpadd_pkg::W-1:0] tab_x   [N_VEC];
  logic [fpadd_pkg::W-1:0] tab_y   [N_VEC];
  logic                    tab_sub [N_VEC];
  logic [fpadd_pkg::W-1:0] tab_res [N_VEC];
  logic [2:0]              tab_flg [N_VEC];

  // Table index and accepting cycle of each operation in flight
  int pend_idx[$];
  int pend_cyc[$];

  int cycle        = 0;
  int mismatches   = 0;
  int other_errors = 0;
  int results_seen = 0;
  int rejected     = 0;

  fpadd_top dut (
    .clk         (clk),
    .reset_i     (reset_i),
    .start_i     (start_i),
    .data_x_i    (data_x_i),
    .data_y_i    (data_y_i),
    .add_subt_i  (add_subt_i),
    .busy_o      (busy_o),
    .ready_o     (ready_o),
    .result_o    (result_o),
    .overflow_o  (overflow_o),
    .underflow_o (underflow_o),
    .zero_o      (zero_o)
  );

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  // Rising edges since time zero
  always @(posedge clk) cycle <= cycle + 1;

  // ========================================
  // Table and check helpers
  // ========================================

  task automatic set_vec(input int i, input logic [31:0] x, input logic [31:0] y,
                         input logic sub, input logic [31:0] res, input logic [2:0] flg);
    tab_x[i]   = x;
    tab_y[i]   = y;
    tab_sub[i] = sub;
    tab_res[i] = res;
    tab_flg[i] = flg;
  endtask

  task automatic fill_table();
    // Additions where the second and third carry out
    set_vec(0,  32'h3FC00000, 32'h40100000, 1'b0, 32'h40700000, 3'b000);
    set_vec(1,  32'h3F800000, 32'h3F800000, 1'b0, 32'h40000000, 3'b000);
    set_vec(2,  32'h40400000, 32'h3FC00000, 1'b0, 32'h40900000, 3'b000);
    set_vec(3,  32'h44800000, 32'h3F800000, 1'b0, 32'h44802000, 3'b000);
    // Subtractions with swapped order and mixed signs
    set_vec(4,  32'h3F800000, 32'h40400000, 1'b1, 32'hC0000000, 3'b000);
    set_vec(5,  32'h3F800000, 32'hC0400000, 1'b0, 32'hC0000000, 3'b000);
    set_vec(6,  32'h3F800000, 32'h3F700000, 1'b1, 32'h3D800000, 3'b000);
    set_vec(7,  32'h40700000, 32'h40600000, 1'b1, 32'h3E800000, 3'b000);
    set_vec(8,  32'hC0A00000, 32'h40000000, 1'b0, 32'hC0400000, 3'b000);
    set_vec(9,  32'hC0000000, 32'hBF000000, 1'b1, 32'hBFC00000, 3'b000);
    set_vec(10, 32'h3F000000, 32'hC0800000, 1'b1, 32'h40900000, 3'b000);
    // Exact cancellation
    set_vec(11, 32'h40200000, 32'h40200000, 1'b1, 32'h00000000, 3'b001);
    set_vec(12, 32'hC0E00000, 32'h40E00000, 1'b0, 32'h00000000, 3'b001);
    // Range limits
    set_vec(13, 32'h7F000000, 32'h7F000000, 1'b0, 32'h7F800000, 3'b100);
    set_vec(14, 32'hFF400000, 32'h7F400000, 1'b1, 32'hFF800000, 3'b100);
    set_vec(15, 32'h00C00000, 32'h00800000, 1'b1, 32'h00000000, 3'b010);
    set_vec(16, 32'h80C00000, 32'h00800000, 1'b0, 32'h80000000, 3'b010);
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      mismatches++;
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      mismatches++;
      $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic print_counts();
    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
  endtask

  // ========================================
  // Result collector
  // ========================================

  initial begin : collect
    int idx;
    int start_cyc;
    forever begin
      @(negedge clk);
      if (!reset_i && ready_o) begin
        assert (pend_idx.size() > 0) else begin
          other_errors++;
          $display("ERROR t=%0t ready_o rose with no operation in flight", $time);
        end
        if (pend_idx.size() > 0) begin
          idx       = pend_idx.pop_front();
          start_cyc = pend_cyc.pop_front();
          results_seen++;
          assert (cycle - start_cyc == 7) else begin
            other_errors++;
            $display("ERROR t=%0t entry %0d finished %0d cycles after its start, not 7",
                     $time, idx, cycle - start_cyc);
          end
          check_word("result_o", result_o, tab_res[idx]);
          check_bit("overflow_o", overflow_o, tab_flg[idx][2]);
          check_bit("underflow_o", underflow_o, tab_flg[idx][1]);
          check_bit("zero_o", zero_o, tab_flg[idx][0]);
        end
      end
    end
  end

  // ========================================
  // Stimulus
  // ========================================

  initial begin : stimulus
    int i;
    reset_i    = 1'b1;
    start_i    = 1'b0;
    data_x_i   = '0;
    data_y_i   = '0;
    add_subt_i = 1'b0;
    fill_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    // Idle outputs before the first start
    repeat (3) begin
      @(negedge clk);
      check_bit("ready_o", ready_o, 1'b0);
      check_bit("busy_o", busy_o, 1'b0);
      check_word("result_o", result_o, '0);
      check_bit("overflow_o", overflow_o, 1'b0);
      check_bit("underflow_o", underflow_o, 1'b0);
      check_bit("zero_o", zero_o, 1'b0);
    end
    // Start stays high and table entries go in whenever busy is low
    i = 0;
    while (i < N_VEC) begin
      @(negedge clk);
      start_i = 1'b1;
      if (busy_o) begin
        // Dropped start whose 10 + 10 must never come out
        data_x_i   = 32'h41200000;
        data_y_i   = 32'h41200000;
        add_subt_i = 1'b0;
        rejected++;
      end else begin
        data_x_i   = tab_x[i];
        data_y_i   = tab_y[i];
        add_subt_i = tab_sub[i];
        pend_idx.push_back(i);
        pend_cyc.push_back(cycle + 1);
        i++;
      end
    end
    @(negedge clk);
    start_i = 1'b0;
    while (pend_idx.size() > 0) @(negedge clk);
    // Window for any stray result
    repeat (12) @(negedge clk);
    assert (results_seen == N_VEC) else begin
      other_errors++;
      $display("ERROR got %0d results for %0d table entries", results_seen, N_VEC);
    end
    assert (rejected > 0) else begin
      other_errors++;
      $display("ERROR no start was ever offered while busy_o was high");
    end
    print_counts();
    if (mismatches == 0 && other_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // ========================================
  // Watchdog
  // ========================================

  initial begin : watchdog
    #(WD_CYCLES * PERIOD);
    $display("TIMEOUT t=%0t run did not finish, %0d operations still in flight",
             $time, pend_idx.size());
    print_counts();
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
hdl/fpadd_pkg.sv
hdl/fpadd_stage_ctrl.sv
hdl/fpadd_operand_sort.sv
hdl/fpadd_barrel_shifter.sv
hdl/fpadd_lzd.sv
hdl/fpadd_formatter.sv
hdl/fpadd_top.sv
testbench/fpadd_chk.sv
testbench/fpadd_tb.sv
